// ==== source/kernel_mac_pkg.sv ====
package kernel_mac_pkg;

  ////////////////////
  // Sizes
  ////////////////////

  // Taps held by each cyclic buffer.
  localparam int buf_depth = 8;

  // Taps carried by one wide write word.
  localparam int write_ratio = 4;

  // Wide words needed to fill one buffer.
  localparam int write_depth = buf_depth / write_ratio;

  // Output pipeline stages behind tap 0.
  localparam int read_latency = 2;

  // Accumulator and sum width, wraps on overflow.
  localparam int acc_width = 24;

  ////////////////////
  // Types
  ////////////////////

  typedef logic signed [7:0] weight_t;
  typedef logic [7:0] pixel_t;
  typedef logic signed [acc_width-1:0] acc_t;

  typedef logic [$clog2(buf_depth)-1:0] r_addr_t;
  typedef logic [$clog2(write_depth)-1:0] w_addr_t;

  // Terms per group, zero counts as one.
  typedef logic [7:0] term_count_t;

endpackage

// ==== source/cyclic_shift_reg.sv ====
module cyclic_shift_reg
  import kernel_mac_pkg::*;
#(
  parameter type tap_t = logic [7:0]
) (
  input  logic                     clk,
  input  logic                     clken,
  input  logic                     rst_n,
  input  logic                     w_en,
  input  logic                     r_en,
  input  tap_t [write_ratio-1:0]   w_data,
  input  w_addr_t                  w_addr_max,
  input  r_addr_t                  r_addr_max,
  output tap_t                     tap
);

  // Tap storage and its next-state values.
  tap_t taps      [buf_depth];
  tap_t rot_src   [buf_depth];
  tap_t next_taps [buf_depth];

  // Output pipeline, stage 0 sits directly behind tap 0.
  tap_t pipe [read_latency];

  logic [buf_depth-1:0] w_sel;
  logic [buf_depth-1:0] tap_load;

  w_addr_t w_addr;
  w_addr_t w_addr_next;

  logic rd;

  assign rd = clken && r_en;

  ////////////////////
  // Write address
  ////////////////////

  // The wide-word slot advances after each write and wraps after w_addr_max.
  assign w_addr_next = (w_addr == w_addr_max) ? '0 : w_addr + 1'b1;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      w_addr <= '0;
    end else if (clken && w_en) begin
      w_addr <= w_addr_next;
    end
  end

  ////////////////////
  // Tap selection
  ////////////////////

  always_comb begin
    for (int i = 0; i < buf_depth; i++) begin
      // Taps covered by the current wide slot take the incoming word.
      w_sel[i] = w_en && (w_addr == w_addr_t'(i / write_ratio));

      // The last tap of the rotation closes the loop back to tap 0.
      if (r_addr_t'(i) == r_addr_max) begin
        rot_src[i] = taps[0];
      end else begin
        rot_src[i] = taps[(i + 1) % buf_depth];
      end

      // A write wins over the shift, but only on the written taps.
      next_taps[i] = w_sel[i] ? w_data[i % write_ratio] : rot_src[i];

      tap_load[i] = clken && (r_en || w_sel[i]);
    end
  end

  ////////////////////
  // Tap registers
  ////////////////////

  for (genvar g = 0; g < buf_depth; g++) begin : g_tap
    always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
        taps[g] <= '0;
      end else if (tap_load[g]) begin
        taps[g] <= next_taps[g];
      end
    end
  end

  ////////////////////
  // Read pipeline
  ////////////////////

  // Stages move only on reads, so the output lags tap 0 by read_latency reads.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int s = 0; s < read_latency; s++) begin
        pipe[s] <= '0;
      end
    end else if (rd) begin
      pipe[0] <= taps[0];
      for (int s = 1; s < read_latency; s++) begin
        pipe[s] <= pipe[s-1];
      end
    end
  end

  assign tap = pipe[read_latency-1];

endmodule

// ==== source/mac_accumulator.sv ====
module mac_accumulator
  import kernel_mac_pkg::*;
(
  input  logic        clk,
  input  logic        clken,
  input  logic        rst_n,
  input  logic        r_en,
  input  weight_t     weight_tap,
  input  pixel_t      pixel_tap,
  input  term_count_t term_count,
  output acc_t        sum,
  output logic        sum_valid
);

  acc_t        product;
  acc_t        total;
  acc_t        total_next;
  term_count_t count;
  term_count_t count_next;
  term_count_t group_len;
  logic        rd;
  logic        group_done;

  assign rd = clken && r_en;

  ////////////////////
  // Datapath
  ////////////////////

  // Pixels are unsigned, so they are zero-extended before the signed multiply.
  // The product is taken at accumulator width and wraps with the total.
  assign product = acc_t'(weight_tap) * acc_t'(pixel_tap);

  assign total_next = total + product;
  assign count_next = count + 1'b1;

  ////////////////////
  // Group tracking
  ////////////////////

  // A zero term count behaves like a group of one.
  assign group_len = (term_count == '0) ? term_count_t'(1) : term_count;

  // Greater-or-equal also closes a group if term_count shrinks mid-group.
  assign group_done = rd && (count_next >= group_len);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      total <= '0;
      count <= '0;
    end else if (rd) begin
      if (group_done) begin
        total <= '0;
        count <= '0;
      end else begin
        total <= total_next;
        count <= count_next;
      end
    end
  end

  ////////////////////
  // Result
  ////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sum <= '0;
    end else if (group_done) begin
      sum <= total_next;
    end
  end

  // The pulse lasts one clock even if clken drops right after the last read.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sum_valid <= 1'b0;
    end else begin
      sum_valid <= group_done;
    end
  end

endmodule

// ==== source/kernel_mac_top.sv ====
module kernel_mac_top
  import kernel_mac_pkg::*;
(
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       clken,

  input  logic                       weight_w_en,
  input  weight_t [write_ratio-1:0]  weight_w_data,
  input  w_addr_t                    weight_w_addr_max,
  input  r_addr_t                    weight_r_addr_max,

  input  logic                       pixel_w_en,
  input  pixel_t [write_ratio-1:0]   pixel_w_data,
  input  w_addr_t                    pixel_w_addr_max,
  input  r_addr_t                    pixel_r_addr_max,

  input  logic                       r_en,
  input  term_count_t                term_count,

  output weight_t                    weight_tap,
  output pixel_t                     pixel_tap,
  output acc_t                       sum,
  output logic                       sum_valid
);

  ////////////////////
  // Tap buffers
  ////////////////////

  // Both buffers see the same r_en and clken, which keeps their taps in step.
  cyclic_shift_reg #(
    .tap_t      (weight_t)
  ) weight_buf (
    .clk        (clk),
    .clken      (clken),
    .rst_n      (rst_n),
    .w_en       (weight_w_en),
    .r_en       (r_en),
    .w_data     (weight_w_data),
    .w_addr_max (weight_w_addr_max),
    .r_addr_max (weight_r_addr_max),
    .tap        (weight_tap)
  );

  cyclic_shift_reg #(
    .tap_t      (pixel_t)
  ) pixel_buf (
    .clk        (clk),
    .clken      (clken),
    .rst_n      (rst_n),
    .w_en       (pixel_w_en),
    .r_en       (r_en),
    .w_data     (pixel_w_data),
    .w_addr_max (pixel_w_addr_max),
    .r_addr_max (pixel_r_addr_max),
    .tap        (pixel_tap)
  );

  ////////////////////
  // Dot product
  ////////////////////

  // The accumulator consumes the taps as they stand before each read edge.
  mac_accumulator mac (
    .clk        (clk),
    .clken      (clken),
    .rst_n      (rst_n),
    .r_en       (r_en),
    .weight_tap (weight_tap),
    .pixel_tap  (pixel_tap),
    .term_count (term_count),
    .sum        (sum),
    .sum_valid  (sum_valid)
  );

endmodule

// ==== verification/kernel_mac_properties.sv ====
module kernel_mac_properties
  import kernel_mac_pkg::*;
(
  input logic    clk,
  input logic    rst_n,
  input logic    clken,
  input logic    r_en,
  input weight_t weight_tap,
  input pixel_t  pixel_tap,
  input acc_t    sum,
  input logic    sum_valid
);

  // A pulse is the echo of an enabled read one edge earlier.
  valid_after_read: assert property (
    @(posedge clk) disable iff (!rst_n)
    sum_valid |-> $past(clken && r_en)
  ) else $error("sum_valid rose without an enabled read before it");

  // With clken low the whole datapath freezes.
  stall_holds: assert property (
    @(posedge clk) disable iff (!rst_n)
    !clken |=> ($stable(weight_tap) && $stable(pixel_tap) && $stable(sum))
  ) else $error("an output moved while clken was low");

  // No stale pulse may leak out of reset.
  reset_clears_valid: assert property (
    @(posedge clk)
    $rose(rst_n) |-> !sum_valid
  ) else $error("sum_valid was set in the first cycle after reset");

endmodule

bind kernel_mac_top kernel_mac_properties props_i (
  .clk        (clk),
  .rst_n      (rst_n),
  .clken      (clken),
  .r_en       (r_en),
  .weight_tap (weight_tap),
  .pixel_tap  (pixel_tap),
  .sum        (sum),
  .sum_valid  (sum_valid)
);

// ==== verification/kernel_mac_tb.sv ====
module kernel_mac_tb
  import kernel_mac_pkg::*;
;

  localparam int clk_period        = 8;
  localparam int reset_cycles      = 5;
  localparam int idle_cycles       = 2;
  localparam int full_read_cycles  = 48;
  localparam int short_read_cycles = 48;
  localparam int mixed_cycles      = 400;
  localparam int group_rounds      = 8;
  localparam int group_cycles      = 150;
  localparam int stall_cycles      = 500;
  localparam int program_count     = 4 + group_rounds;
  localparam int total_cycles = reset_cycles + write_depth + full_read_cycles
    + short_read_cycles + mixed_cycles + group_rounds * group_cycles + stall_cycles
    + program_count * idle_cycles + 1;

  logic                      clk = 1'b0;
  logic                      rst_n;
  logic                      clken;
  logic                      weight_w_en;
  weight_t [write_ratio-1:0] weight_w_data;
  w_addr_t                   weight_w_addr_max;
  r_addr_t                   weight_r_addr_max;
  logic                      pixel_w_en;
  pixel_t [write_ratio-1:0]  pixel_w_data;
  w_addr_t                   pixel_w_addr_max;
  r_addr_t                   pixel_r_addr_max;
  logic                      r_en;
  term_count_t               term_count;
  weight_t                   weight_tap;
  pixel_t                    pixel_tap;
  acc_t                      sum;
  logic                      sum_valid;

  // Model state. Index 0 holds the weight buffer and index 1 the pixel buffer.
  logic [7:0] m_taps [2][buf_depth];
  logic [7:0] m_pipe [2][read_latency];
  int         m_waddr [2];
  acc_t       m_total;
  int         m_count;
  acc_t       m_sum;
  logic       m_valid;
  int         pulses;

  // Words written by the full fill, in tap order.
  weight_t w_fill [buf_depth];
  pixel_t  p_fill [buf_depth];

  weight_t w_seen [$];
  pixel_t  p_seen [$];

  kernel_mac_top kernel_mac_top_i (
    .clk               (clk),
    .rst_n             (rst_n),
    .clken             (clken),
    .weight_w_en       (weight_w_en),
    .weight_w_data     (weight_w_data),
    .weight_w_addr_max (weight_w_addr_max),
    .weight_r_addr_max (weight_r_addr_max),
    .pixel_w_en        (pixel_w_en),
    .pixel_w_data      (pixel_w_data),
    .pixel_w_addr_max  (pixel_w_addr_max),
    .pixel_r_addr_max  (pixel_r_addr_max),
    .r_en              (r_en),
    .term_count        (term_count),
    .weight_tap        (weight_tap),
    .pixel_tap         (pixel_tap),
    .sum               (sum),
    .sum_valid         (sum_valid)
  );

  always #(clk_period / 2) clk = ~clk;

  ////////////////////
  // Checking
  ////////////////////

  task automatic abort_run(input string why);
    $display("Result: FAILED");
    $fatal(1, why);
  endtask

  task automatic check_weight(input weight_t expected, input weight_t actual);
    if (actual !== expected) begin
      $display("ERR t=%0t weight_tap expected=%0d actual=%0d", $time, expected, actual);
      abort_run("weight_tap mismatch");
    end
  endtask

  task automatic check_pixel(input pixel_t expected, input pixel_t actual);
    if (actual !== expected) begin
      $display("ERR t=%0t pixel_tap expected=%0d actual=%0d", $time, expected, actual);
      abort_run("pixel_tap mismatch");
    end
  endtask

  task automatic check_sum(input acc_t expected, input acc_t actual);
    if (actual !== expected) begin
      $display("ERR t=%0t sum expected=%0d actual=%0d", $time, expected, actual);
      abort_run("sum mismatch");
    end
  endtask

  task automatic check_valid(input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("ERR t=%0t sum_valid expected=%0b actual=%0b", $time, expected, actual);
      abort_run("sum_valid mismatch");
    end
  endtask

  task automatic check_outputs();
    check_weight(weight_t'(m_pipe[0][read_latency-1]), weight_tap);
    check_pixel(pixel_t'(m_pipe[1][read_latency-1]), pixel_tap);
    check_sum(m_sum, sum);
    check_valid(m_valid, sum_valid);
    if (m_valid) begin
      pulses++;
    end
  endtask

  // Tap 0 feeds the read pipeline, so each recorded sample is the tap 0 value
  // from read_latency-1 reads before it. The rotation starts start taps into the fill.
  task automatic check_rotation(input int start, input int w_period, input int p_period);
    int idx;
    for (int n = read_latency - 1; n < w_seen.size(); n++) begin
      idx = n - read_latency + 1;
      check_weight(w_fill[(idx % w_period + start) % buf_depth], w_seen[n]);
      check_pixel(p_fill[(idx % p_period + start) % buf_depth], p_seen[n]);
    end
  endtask

  ////////////////////
  // Model
  ////////////////////

  task automatic step_buffer(input int b, input logic we, input logic [write_ratio*8-1:0] wdata,
                             input int waddr_max, input int raddr_max);
    logic [7:0] old_taps [buf_depth];
    int         base;
    for (int i = 0; i < buf_depth; i++) begin
      old_taps[i] = m_taps[b][i];
    end
    if (clken && r_en) begin
      for (int s = read_latency - 1; s > 0; s--) begin
        m_pipe[b][s] = m_pipe[b][s-1];
      end
      m_pipe[b][0] = old_taps[0];
      for (int i = 0; i < buf_depth; i++) begin
        m_taps[b][i] = (i == raddr_max) ? old_taps[0] : old_taps[(i + 1) % buf_depth];
      end
    end
    // Written taps take the new word whatever the rotation did.
    if (clken && we) begin
      base = m_waddr[b] * write_ratio;
      for (int k = 0; k < write_ratio; k++) begin
        m_taps[b][base + k] = wdata[k*8 +: 8];
      end
      m_waddr[b] = (m_waddr[b] == waddr_max) ? 0 : (m_waddr[b] + 1) % write_depth;
    end
  endtask

  task automatic model_step();
    int prod;
    int len;
    m_valid = 1'b0;
    // The product uses the taps as they stood before this edge.
    if (clken && r_en) begin
      prod = int'(weight_t'(m_pipe[0][read_latency-1])) * int'(m_pipe[1][read_latency-1]);
      m_total = acc_t'(int'(m_total) + prod);
      m_count++;
      len = (term_count == '0) ? 1 : int'(term_count);
      if (m_count >= len) begin
        m_sum   = m_total;
        m_total = '0;
        m_count = 0;
        m_valid = 1'b1;
      end
    end
    step_buffer(0, weight_w_en, weight_w_data, int'(weight_w_addr_max),
                int'(weight_r_addr_max));
    step_buffer(1, pixel_w_en, pixel_w_data, int'(pixel_w_addr_max), int'(pixel_r_addr_max));
  endtask

  ////////////////////
  // Stimulus
  ////////////////////

  function automatic bit chance(input int pct);
    return int'($urandom_range(99, 0)) < pct;
  endfunction

  task automatic step_and_check();
    @(posedge clk);
    model_step();
    #1;
    check_outputs();
  endtask

  task automatic drive_random(input int clken_pct, input int w_pct, input int r_pct);
    clken       = chance(clken_pct);
    weight_w_en = chance(w_pct);
    pixel_w_en  = chance(w_pct);
    r_en        = chance(r_pct);
    for (int k = 0; k < write_ratio; k++) begin
      weight_w_data[k] = weight_t'($urandom_range(255, 0));
      pixel_w_data[k]  = pixel_t'($urandom_range(255, 0));
    end
  endtask

  task automatic program_settings(input w_addr_t ww_max, input r_addr_t wr_max,
                                  input w_addr_t pw_max, input r_addr_t pr_max,
                                  input term_count_t tc);
    clken             = 1'b1;
    r_en              = 1'b0;
    weight_w_en       = 1'b0;
    pixel_w_en        = 1'b0;
    weight_w_addr_max = ww_max;
    weight_r_addr_max = wr_max;
    pixel_w_addr_max  = pw_max;
    pixel_r_addr_max  = pr_max;
    term_count        = tc;
    repeat (idle_cycles) step_and_check();
  endtask

  task automatic program_random(input term_count_t tc);
    program_settings(w_addr_t'($urandom_range(write_depth - 1, 0)),
                     r_addr_t'($urandom_range(buf_depth - 1, 0)),
                     w_addr_t'($urandom_range(write_depth - 1, 0)),
                     r_addr_t'($urandom_range(buf_depth - 1, 0)), tc);
  endtask

  task automatic run_phase(input int cycles, input int clken_pct, input int w_pct,
                           input int r_pct);
    repeat (cycles) begin
      drive_random(clken_pct, w_pct, r_pct);
      step_and_check();
    end
  endtask

  task automatic read_and_record(input int cycles);
    w_seen.delete();
    p_seen.delete();
    repeat (cycles) begin
      drive_random(100, 0, 100);
      step_and_check();
      w_seen.push_back(weight_tap);
      p_seen.push_back(pixel_tap);
    end
  endtask

  ////////////////////
  // Sequence
  ////////////////////

  initial begin
    r_addr_t     short_max;
    term_count_t tc;
    void'($urandom(36));
    rst_n             = 1'b0;
    clken             = 1'b0;
    weight_w_en       = 1'b0;
    weight_w_data     = '0;
    weight_w_addr_max = '0;
    weight_r_addr_max = '0;
    pixel_w_en        = 1'b0;
    pixel_w_data      = '0;
    pixel_w_addr_max  = '0;
    pixel_r_addr_max  = '0;
    r_en              = 1'b0;
    term_count        = '0;
    for (int b = 0; b < 2; b++) begin
      for (int i = 0; i < buf_depth; i++) begin
        m_taps[b][i] = '0;
      end
      for (int s = 0; s < read_latency; s++) begin
        m_pipe[b][s] = '0;
      end
      m_waddr[b] = 0;
    end
    m_total = '0;
    m_count = 0;
    m_sum   = '0;
    m_valid = 1'b0;
    pulses  = 0;

    repeat (reset_cycles) @(posedge clk);
    #1;
    rst_n = 1'b1;
    check_weight('0, weight_tap);
    check_pixel('0, pixel_tap);
    check_sum('0, sum);
    check_valid(1'b0, sum_valid);

    // Fill both buffers completely, then rotate over all eight taps.
    program_settings(w_addr_t'(write_depth - 1), r_addr_t'(buf_depth - 1),
                     w_addr_t'(write_depth - 1), r_addr_t'(buf_depth - 1),
                     term_count_t'($urandom_range(8, 1)));
    for (int j = 0; j < write_depth; j++) begin
      drive_random(100, 100, 0);
      for (int k = 0; k < write_ratio; k++) begin
        w_fill[j * write_ratio + k] = weight_w_data[k];
        p_fill[j * write_ratio + k] = pixel_w_data[k];
      end
      step_and_check();
    end
    read_and_record(full_read_cycles);
    check_rotation(0, buf_depth, buf_depth);

    short_max = r_addr_t'($urandom_range(5, 1));
    program_settings(w_addr_t'(write_depth - 1), short_max, w_addr_t'(write_depth - 1),
                     r_addr_t'(buf_depth - 1), term_count_t'($urandom_range(8, 1)));
    read_and_record(short_read_cycles);
    check_rotation(full_read_cycles % buf_depth, int'(short_max) + 1, buf_depth);

    program_random(term_count_t'($urandom_range(8, 1)));
    run_phase(mixed_cycles, 100, 20, 60);

    for (int round = 0; round < group_rounds; round++) begin
      if (round < 2) begin
        tc = term_count_t'(round);
      end else begin
        tc = term_count_t'($urandom_range(12, 2));
      end
      program_random(tc);
      run_phase(group_cycles, 100, 20, 60);
    end

    program_random(term_count_t'($urandom_range(6, 0)));
    run_phase(stall_cycles, 85, 20, 60);

    if (pulses == 0) begin
      $display("No sum_valid pulse was seen during the whole run");
      abort_run("no group sums");
    end else begin
      $display("Result: PASSED");
      $finish;
    end
  end

  initial begin
    #((total_cycles + 200) * clk_period);
    $display("Run timed out at %0t before all test phases completed", $time);
    abort_run("timeout");
  end

endmodule

// ==== kernel_mac.f ====
source/kernel_mac_pkg.sv
source/cyclic_shift_reg.sv
source/mac_accumulator.sv
source/kernel_mac_top.sv
verification/kernel_mac_properties.sv
verification/kernel_mac_tb.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  --top-module kernel_mac_tb \
  -f kernel_mac.f \
  -o kernel_mac_sim \
  && ./obj_dir/kernel_mac_sim \
  && echo "simulation finished cleanly" \
  || { echo "build or simulation failed"; exit 1; }
